// ==== src/tile_cfg_pkg.sv ====
/*
 * Widths, requester ids and encodings shared by the data-memory port.
 * Imported by the bus record package and every RTL module.
 */
`default_nettype none

package tile_cfg_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int unsigned ADDR_W    = 40;
    localparam int unsigned DATA_W    = 64;
    localparam int unsigned BE_W      = DATA_W / 8;
    localparam int unsigned SIZE_W    = 3;
    localparam int unsigned PTW_CMD_W = 5;

    // --------------------
    // Requesters
    // --------------------
    // Requester count is tied to the sid encoding
    localparam int unsigned NREQ  = 2;
    localparam int unsigned SID_W = 1;

    localparam logic [SID_W-1:0] SID_PTW  = 1'b0;
    localparam logic [SID_W-1:0] SID_CORE = 1'b1;

    // Walker command that maps to an atomic OR
    localparam logic [PTW_CMD_W-1:0] PTW_CMD_AMO_OR = 5'b01010;

    // Memory operation codes
    typedef enum logic [1:0] {
        MEM_LOAD   = 2'd0,
        MEM_STORE  = 2'd1,
        MEM_AMO_OR = 2'd2
    } mem_op_e;

endpackage

`default_nettype wire

// ==== src/tile_mem_pkg.sv ====
/*
 * Bus records for requester requests, memory requests and responses.
 * Built on the constants of the configuration package.
 */
`default_nettype none

package tile_mem_pkg;

    import tile_cfg_pkg::*;

    // --------------------
    // Requester side
    // --------------------

    // Walker request, command still raw
    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        logic [DATA_W-1:0]    data;
        logic [PTW_CMD_W-1:0] cmd;
        logic [SIZE_W-1:0]    size;
    } ptw_req_t;

    // Load/store path request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        mem_op_e           op;
        logic [BE_W-1:0]   be;
        logic [SIZE_W-1:0] size;
        logic              need_rsp;
    } core_req_t;

    // --------------------
    // Memory side
    // --------------------

    // Same fields as core_req_t, tagged with the requester id
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        mem_op_e           op;
        logic [BE_W-1:0]   be;
        logic [SIZE_W-1:0] size;
        logic              need_rsp;
        logic [SID_W-1:0]  sid;
    } mem_req_t;

    // Read response, steered back by sid
    typedef struct packed {
        logic [SID_W-1:0]  sid;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

    // Arbiter to router, one per accepted request
    typedef struct packed {
        logic             valid;
        logic [SID_W-1:0] sid;
        logic             need_rsp;
    } issue_t;

endpackage

`default_nettype wire

// ==== src/ptw_req_decode.sv ====
/*
 * Translates a page table walker request into a memory request.
 * Purely combinational, sits in front of the arbiter's walker input.
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_req_decode
    import tile_cfg_pkg::*, tile_mem_pkg::*;
(
    // Raw walker request
    input  ptw_req_t ptw_req_i,

    // Decoded request toward the arbiter
    output mem_req_t mem_req_o
);

    // --------------------
    // Command decode
    // --------------------

    // Only one walker command is special, the rest are plain loads
    logic is_amo_or;

    assign is_amo_or = (ptw_req_i.cmd == PTW_CMD_AMO_OR);

    // --------------------
    // Request build
    // --------------------

    always_comb begin
        // Address, data and size go through untouched
        mem_req_o.addr  = ptw_req_i.addr;
        mem_req_o.wdata = ptw_req_i.data;
        mem_req_o.size  = ptw_req_i.size;

        // AMO-OR writes the whole word, a load writes nothing
        if (is_amo_or) begin
            mem_req_o.op = MEM_AMO_OR;
            mem_req_o.be = {BE_W{1'b1}};
        end else begin
            mem_req_o.op = MEM_LOAD;
            mem_req_o.be = {BE_W{1'b0}};
        end

        // Walker always waits for its data
        mem_req_o.need_rsp = 1'b1;
        mem_req_o.sid      = SID_PTW;
    end

endmodule

`default_nettype wire

// ==== src/dmem_arbiter.sv ====
/*
 * Fixed-priority arbiter between walker and load/store path, with one
 * registered slot toward memory. Walker wins when both are eligible.
 */
`timescale 1ns/1ps
`default_nettype none

module dmem_arbiter
    import tile_cfg_pkg::*, tile_mem_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,

    // Walker, already decoded
    input  logic            ptw_valid_i,
    output logic            ptw_ready_o,
    input  mem_req_t        ptw_req_i,

    // Load/store path
    input  logic            core_valid_i,
    output logic            core_ready_o,
    input  core_req_t       core_req_i,

    // Outstanding flags from the router
    input  logic [NREQ-1:0] busy_i,

    // Memory request port
    output logic            mem_req_valid_o,
    input  logic            mem_req_ready_i,
    output mem_req_t        mem_req_o,

    // Acceptance pulse to the router
    output issue_t          issue_o
);

    logic     slot_valid_q;
    mem_req_t slot_q;

    logic     slot_free;
    logic     grant_ptw;
    logic     grant_core;
    logic     grant_any;
    mem_req_t core_req_tagged;
    mem_req_t slot_d;

    // --------------------
    // Grant
    // --------------------

    // Slot takes a new entry when empty or draining this cycle
    assign slot_free = !slot_valid_q || mem_req_ready_i;

    assign ptw_ready_o  = slot_free && !busy_i[SID_PTW];
    // Core is held off while the walker takes the slot
    assign core_ready_o = slot_free && !busy_i[SID_CORE] && !(ptw_valid_i && ptw_ready_o);

    assign grant_ptw  = ptw_valid_i && ptw_ready_o;
    assign grant_core = core_valid_i && core_ready_o;
    assign grant_any  = grant_ptw || grant_core;

    always_comb begin
        core_req_tagged.addr     = core_req_i.addr;
        core_req_tagged.wdata    = core_req_i.wdata;
        core_req_tagged.op       = core_req_i.op;
        core_req_tagged.be       = core_req_i.be;
        core_req_tagged.size     = core_req_i.size;
        core_req_tagged.need_rsp = core_req_i.need_rsp;
        core_req_tagged.sid      = SID_CORE;
    end

    assign slot_d = grant_ptw ? ptw_req_i : core_req_tagged;

    // One pulse per accepted request
    assign issue_o.valid    = grant_any;
    assign issue_o.sid      = slot_d.sid;
    assign issue_o.need_rsp = slot_d.need_rsp;

    // --------------------
    // Output slot
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            slot_valid_q <= 1'b0;
        end else if (grant_any) begin
            slot_valid_q <= 1'b1;
        end else if (mem_req_ready_i) begin
            slot_valid_q <= 1'b0;
        end
    end

    // Payload only moves on a grant
    always_ff @(posedge clk_i) begin
        if (grant_any) begin
            slot_q <= slot_d;
        end
    end

    assign mem_req_valid_o = slot_valid_q;
    assign mem_req_o       = slot_q;

endmodule

`default_nettype wire

// ==== src/dmem_resp_router.sv ====
/*
 * Tracks one outstanding request per requester and steers memory
 * responses back by sid. Busy flags throttle the arbiter.
 */
`timescale 1ns/1ps
`default_nettype none

module dmem_resp_router
    import tile_cfg_pkg::*, tile_mem_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Accepted request from the arbiter
    input  issue_t            issue_i,

    // Memory response port, always accepted
    input  logic              mem_rsp_valid_i,
    input  mem_rsp_t          mem_rsp_i,

    // Outstanding flags, indexed by sid
    output logic [NREQ-1:0]   busy_o,

    // Per-requester responses
    output logic              ptw_rsp_valid_o,
    output logic [DATA_W-1:0] ptw_rdata_o,
    output logic              core_rsp_valid_o,
    output logic [DATA_W-1:0] core_rdata_o
);

    logic [NREQ-1:0] busy_q;
    logic [NREQ-1:0] busy_d;

    // --------------------
    // Outstanding flags
    // --------------------

    always_comb begin
        busy_d = busy_q;
        // Response frees its requester
        if (mem_rsp_valid_i) begin
            busy_d[mem_rsp_i.sid] = 1'b0;
        end
        // Fire-and-forget requests leave the flag alone
        if (issue_i.valid && issue_i.need_rsp) begin
            busy_d[issue_i.sid] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    assign busy_o = busy_q;

    // --------------------
    // Response steering
    // --------------------
    assign ptw_rsp_valid_o  = mem_rsp_valid_i && (mem_rsp_i.sid == SID_PTW);
    assign core_rsp_valid_o = mem_rsp_valid_i && (mem_rsp_i.sid == SID_CORE);

    // Data is shared, the valids qualify it
    assign ptw_rdata_o  = mem_rsp_i.rdata;
    assign core_rdata_o = mem_rsp_i.rdata;

endmodule

`default_nettype wire

// ==== src/dmem_port_top.sv ====
/*
 * Data-memory side of the tile: walker decode, arbitration onto one
 * memory port and response routing back to walker and load/store path.
 */
`timescale 1ns/1ps
`default_nettype none

module dmem_port_top
    import tile_cfg_pkg::*, tile_mem_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Page table walker, requester 0
    input  logic              ptw_req_valid_i,
    output logic              ptw_req_ready_o,
    input  ptw_req_t          ptw_req_i,
    output logic              ptw_rsp_valid_o,
    output logic [DATA_W-1:0] ptw_rdata_o,

    // Load/store path, requester 1
    input  logic              core_req_valid_i,
    output logic              core_req_ready_o,
    input  core_req_t         core_req_i,
    output logic              core_rsp_valid_o,
    output logic [DATA_W-1:0] core_rdata_o,

    // Memory
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    output mem_req_t          mem_req_o,
    input  logic              mem_rsp_valid_i,
    input  mem_rsp_t          mem_rsp_i
);

    mem_req_t        ptw_mem_req;
    issue_t          issue;
    logic [NREQ-1:0] busy;

    // --------------------
    // Decode
    // --------------------
    ptw_req_decode i_ptw_req_decode (
        .ptw_req_i ( ptw_req_i   ),
        .mem_req_o ( ptw_mem_req )
    );

    // --------------------
    // Issue
    // --------------------
    dmem_arbiter i_dmem_arbiter (
        .clk_i           ( clk_i            ),
        .rst_n_i         ( rst_n_i          ),
        .ptw_valid_i     ( ptw_req_valid_i  ),
        .ptw_ready_o     ( ptw_req_ready_o  ),
        .ptw_req_i       ( ptw_mem_req      ),
        .core_valid_i    ( core_req_valid_i ),
        .core_ready_o    ( core_req_ready_o ),
        .core_req_i      ( core_req_i       ),
        .busy_i          ( busy             ),
        .mem_req_valid_o ( mem_req_valid_o  ),
        .mem_req_ready_i ( mem_req_ready_i  ),
        .mem_req_o       ( mem_req_o        ),
        .issue_o         ( issue            )
    );

    // --------------------
    // Result
    // --------------------
    dmem_resp_router i_dmem_resp_router (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .issue_i          ( issue            ),
        .mem_rsp_valid_i  ( mem_rsp_valid_i  ),
        .mem_rsp_i        ( mem_rsp_i        ),
        .busy_o           ( busy             ),
        .ptw_rsp_valid_o  ( ptw_rsp_valid_o  ),
        .ptw_rdata_o      ( ptw_rdata_o      ),
        .core_rsp_valid_o ( core_rsp_valid_o ),
        .core_rdata_o     ( core_rdata_o     )
    );

endmodule

`default_nettype wire

// ==== bench/dmem_port_chk.sv ====
/*
 * Handshake and routing assertions, bound into the data-memory port top.
 */
`timescale 1ns/1ps
`default_nettype none

module dmem_port_chk
    import tile_cfg_pkg::*, tile_mem_pkg::*;
(
    input wire logic            clk_i,
    input wire logic            rst_n_i,
    input wire logic            ptw_req_valid_i,
    input wire logic            core_req_valid_i,
    input wire core_req_t       core_req_i,
    input wire logic            mem_req_valid_o,
    input wire logic            mem_req_ready_i,
    input wire mem_req_t        mem_req_o,
    input wire logic            ptw_req_ready_o,
    input wire logic            core_req_ready_o,
    input wire logic            ptw_rsp_valid_o,
    input wire logic            core_rsp_valid_o,
    input wire logic [NREQ-1:0] busy
);

    // Unanswered requests as seen from the requester handshakes
    logic ptw_owed_q;
    logic core_owed_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptw_owed_q  <= 1'b0;
            core_owed_q <= 1'b0;
        end else begin
            if (ptw_req_valid_i && ptw_req_ready_o) begin
                ptw_owed_q <= 1'b1;
            end else if (ptw_rsp_valid_o) begin
                ptw_owed_q <= 1'b0;
            end
            if (core_req_valid_i && core_req_ready_o && core_req_i.need_rsp) begin
                core_owed_q <= 1'b1;
            end else if (core_rsp_valid_o) begin
                core_owed_q <= 1'b0;
            end
        end
    end

    // Request held until memory takes it
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
        else $error("memory request dropped or changed under back-pressure");

    // Responses only for outstanding requests
    a_ptw_rsp_owed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ptw_rsp_valid_o |-> busy[SID_PTW])
        else $error("walker response without outstanding request");

    a_core_rsp_owed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_rsp_valid_o |-> busy[SID_CORE])
        else $error("core response without outstanding request");

    // One outstanding request per requester
    a_ptw_busy_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ptw_owed_q |-> busy[SID_PTW] && !ptw_req_ready_o)
        else $error("walker ready while busy");

    a_core_busy_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_owed_q |-> busy[SID_CORE] && !core_req_ready_o)
        else $error("core ready while busy");

    a_rsp_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ptw_rsp_valid_o && core_rsp_valid_o))
        else $error("both response valids high");

endmodule

bind dmem_port_top dmem_port_chk i_dmem_port_chk (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .ptw_req_valid_i  ( ptw_req_valid_i  ),
    .core_req_valid_i ( core_req_valid_i ),
    .core_req_i       ( core_req_i       ),
    .mem_req_valid_o  ( mem_req_valid_o  ),
    .mem_req_ready_i  ( mem_req_ready_i  ),
    .mem_req_o        ( mem_req_o        ),
    .ptw_req_ready_o  ( ptw_req_ready_o  ),
    .core_req_ready_o ( core_req_ready_o ),
    .ptw_rsp_valid_o  ( ptw_rsp_valid_o  ),
    .core_rsp_valid_o ( core_rsp_valid_o ),
    .busy             ( busy             )
);

`default_nettype wire

// ==== bench/tb_dmem_port.sv ====
/*
 * Testbench for the data-memory port: directed and random walker and core
 * traffic against a memory model, checked by a shadow-memory reference.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dmem_port
    import tile_cfg_pkg::*, tile_mem_pkg::*;
();

    localparam time CLK_PERIOD = 100;
    localparam int  N_RAND     = 40;
    localparam int  N_ITEMS    = 10 + 2 * N_RAND;

    logic clk_i, rst_n_i;
    logic ptw_req_valid_i, ptw_req_ready_o, ptw_rsp_valid_o;
    logic core_req_valid_i, core_req_ready_o, core_rsp_valid_o;
    logic mem_req_valid_o, mem_req_ready_i, mem_rsp_valid_i;
    logic [DATA_W-1:0] ptw_rdata_o, core_rdata_o;
    ptw_req_t  ptw_req_i;
    core_req_t core_req_i;
    mem_req_t  mem_req_o;
    mem_rsp_t  mem_rsp_i;

    logic [31:0]       lfsr_q = 32'h6c1c_7e74;
    logic [DATA_W-1:0] mem_words [64];
    logic [DATA_W-1:0] shadow [64];
    mem_req_t          want_ptw[$], want_core[$];
    logic [DATA_W-1:0] exp_ptw[$], exp_core[$];
    logic [DATA_W-1:0] rsp_data[$];
    logic [SID_W-1:0]  rsp_sid[$], port_sids[$];
    int                rsp_due[$];
    int cycle = 0, errors = 0, checks = 0, tests = 0;
    int need_count = 0, rsp_count = 0, test_err0;

    dmem_port_top i_dut (.*);

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] fill_word(input int i);
        return {32'h5a00_0000 | (i * 32'h0101), 32'hc3c3_0000 ^ ((i + 1) * 32'h1f1f)};
    endfunction

    function automatic logic [DATA_W-1:0] be_mask(input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] m;
        for (int b = 0; b < BE_W; b++) begin
            m[8*b +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    // Reference model: every op returns the old word
    function automatic logic [DATA_W-1:0] ref_apply(input mem_req_t r);
        logic [DATA_W-1:0] old;
        logic [DATA_W-1:0] m;
        old = shadow[r.addr[8:3]];
        m   = be_mask(r.be);
        if (r.op == MEM_STORE) begin
            shadow[r.addr[8:3]] = (old & ~m) | (r.wdata & m);
        end else if (r.op == MEM_AMO_OR) begin
            shadow[r.addr[8:3]] = old | (r.wdata & m);
        end
        return old;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // --------------------
    // Clock, reset, watchdog
    // --------------------
    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(N_ITEMS * 20 * CLK_PERIOD);
        $display("Timeout: traffic did not drain in time");
        $display("TEST FAILED");
        $finish;
    end

    // --------------------
    // Memory responder
    // --------------------
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem_words[i] = fill_word(i);
            shadow[i]    = fill_word(i);
        end
        forever begin
            @(posedge clk_i);
            cycle++;
            #10;
            mem_req_ready_i = (take_bits(2) != 0);
            mem_rsp_valid_i = 1'b0;
            if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
                void'(rsp_due.pop_front());
                mem_rsp_i.sid   = rsp_sid.pop_front();
                mem_rsp_i.rdata = rsp_data.pop_front();
                mem_rsp_valid_i = 1'b1;
            end
        end
    end

    // Memory port acceptance, sampled mid-cycle
    always @(negedge clk_i) begin
        logic [DATA_W-1:0] old;
        logic [DATA_W-1:0] m;
        mem_req_t          want;
        if (rst_n_i && mem_req_valid_o && mem_req_ready_i) begin
            port_sids.push_back(mem_req_o.sid);
            if (mem_req_o.sid == SID_PTW ? want_ptw.size() == 0 : want_core.size() == 0) begin
                errors++;
                $display("Unexpected request at the memory port at %0t", $time);
            end else begin
                want = (mem_req_o.sid == SID_PTW) ? want_ptw.pop_front() : want_core.pop_front();
                check_value("mem_req_o.addr", 64'(mem_req_o.addr), 64'(want.addr));
                check_value("mem_req_o.wdata", mem_req_o.wdata, want.wdata);
                check_value("mem_req_o.op", 64'(mem_req_o.op), 64'(want.op));
                check_value("mem_req_o.be", 64'(mem_req_o.be), 64'(want.be));
                check_value("mem_req_o.size", 64'(mem_req_o.size), 64'(want.size));
                check_value("mem_req_o.need_rsp", 64'(mem_req_o.need_rsp), 64'(want.need_rsp));
            end
            old = mem_words[mem_req_o.addr[8:3]];
            m   = be_mask(mem_req_o.be);
            if (mem_req_o.op == MEM_STORE)
                mem_words[mem_req_o.addr[8:3]] = (old & ~m) | (mem_req_o.wdata & m);
            else if (mem_req_o.op == MEM_AMO_OR)
                mem_words[mem_req_o.addr[8:3]] = old | (mem_req_o.wdata & m);
            if (mem_req_o.need_rsp) begin
                rsp_due.push_back(cycle + 1 + int'(take_bits(8) % 6));
                rsp_sid.push_back(mem_req_o.sid);
                rsp_data.push_back(old);
                if (mem_req_o.sid == SID_PTW)
                    exp_ptw.push_back(ref_apply(mem_req_o));
                else
                    exp_core.push_back(ref_apply(mem_req_o));
            end else begin
                void'(ref_apply(mem_req_o));
            end
        end
    end

    // Response compare
    always @(negedge clk_i) begin
        if (rst_n_i && ptw_rsp_valid_o) begin
            rsp_count++;
            if (exp_ptw.size() == 0) begin
                errors++;
                $display("Walker response with none expected at %0t", $time);
            end else begin
                check_value("ptw_rdata_o", ptw_rdata_o, exp_ptw.pop_front());
            end
        end
        if (rst_n_i && core_rsp_valid_o) begin
            rsp_count++;
            if (exp_core.size() == 0) begin
                errors++;
                $display("Core response with none expected at %0t", $time);
            end else begin
                check_value("core_rdata_o", core_rdata_o, exp_core.pop_front());
            end
        end
    end

    // --------------------
    // Drivers, called 10 ns after a rising edge
    // --------------------
    task automatic send_ptw(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [PTW_CMD_W-1:0] cmd);
        mem_req_t want;
        ptw_req_i       = '{addr: addr, data: data, cmd: cmd, size: 3'd3};
        ptw_req_valid_i = 1'b1;
        @(negedge clk_i);
        while (!ptw_req_ready_o) @(negedge clk_i);
        want = '{addr: addr, wdata: data, op: (cmd == 5'b01010) ? MEM_AMO_OR : MEM_LOAD,
                 be: (cmd == 5'b01010) ? 8'hff : 8'h00, size: 3'd3, need_rsp: 1'b1,
                 sid: 1'b0};
        want_ptw.push_back(want);
        // Walker requests always expect an answer
        need_count++;
        @(posedge clk_i);
        #10;
        ptw_req_valid_i = 1'b0;
    endtask

    task automatic send_core(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input mem_op_e op, input logic [BE_W-1:0] be, input logic need);
        core_req_i       = '{addr: addr, wdata: data, op: op, be: be, size: 3'd3,
                             need_rsp: need};
        core_req_valid_i = 1'b1;
        @(negedge clk_i);
        while (!core_req_ready_o) @(negedge clk_i);
        want_core.push_back('{addr: addr, wdata: data, op: op, be: be, size: 3'd3,
                              need_rsp: need, sid: 1'b1});
        if (need) begin
            need_count++;
        end
        @(posedge clk_i);
        #10;
        core_req_valid_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #10;
        end
    endtask

    task automatic drain();
        @(negedge clk_i);
        while (want_ptw.size() || want_core.size() || exp_ptw.size() || exp_core.size()
               || rsp_due.size() || mem_req_valid_o) @(negedge clk_i);
        @(posedge clk_i);
        #10;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%-34s %s", name, (errors == test_err0) ? "ok" : "errors");
        test_err0 = errors;
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        rst_n_i = 1'b0;
        ptw_req_valid_i = 1'b0;
        core_req_valid_i = 1'b0;
        ptw_req_i = '0;
        core_req_i = '0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_i = '0;
        test_err0 = 0;
        repeat (4) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;

        @(negedge clk_i);
        check_value("mem_req_valid_o", 64'(mem_req_valid_o), 64'd0);
        check_value("ptw_rsp_valid_o", 64'(ptw_rsp_valid_o), 64'd0);
        check_value("core_rsp_valid_o", 64'(core_rsp_valid_o), 64'd0);
        check_value("ptw_req_ready_o", 64'(ptw_req_ready_o), 64'd1);
        check_value("core_req_ready_o", 64'(core_req_ready_o), 64'd1);
        @(posedge clk_i);
        #10;
        end_test("1 reset state");

        send_ptw(40'h12_3456_7808, 64'h0, 5'b00000);
        drain();
        end_test("2 walker load");

        send_ptw(40'h00_0000_0110, 64'h8000_0000_0000_0041, 5'b01010);
        send_ptw(40'h00_0000_0110, 64'h0, 5'b00000);
        drain();
        end_test("3 walker AMO-OR then load");

        send_core(40'h20, 64'h1122_3344_5566_7788, MEM_STORE, 8'h0f, 1'b1);
        send_core(40'h28, 64'hdead_beef_0bad_f00d, MEM_STORE, 8'hf0, 1'b0);
        send_core(40'h28, 64'h0, MEM_LOAD, 8'h00, 1'b1);
        send_core(40'h20, 64'h0, MEM_LOAD, 8'h00, 1'b1);
        drain();
        end_test("4 core stores and loads");

        port_sids.delete();
        fork
            send_ptw(40'h40, 64'h0, 5'b00000);
            send_core(40'h48, 64'h0, MEM_LOAD, 8'h00, 1'b1);
        join
        drain();
        check_value("first sid at memory port", 64'(port_sids[0]), 64'(SID_PTW));
        end_test("5 walker priority");

        fork
            for (int i = 0; i < N_RAND; i++) begin
                idle(int'(take_bits(2)));
                send_ptw(take_bits(40), take_bits(64),
                         (take_bits(2) == 0) ? 5'b01010 : 5'(take_bits(5)));
            end
            for (int i = 0; i < N_RAND; i++) begin
                idle(int'(take_bits(2)));
                if (take_bits(1))
                    send_core(take_bits(40), take_bits(64), MEM_STORE, 8'(take_bits(8)),
                              1'(take_bits(1)));
                else
                    send_core(take_bits(40), 64'h0, MEM_LOAD, 8'h00, 1'b1);
            end
        join
        drain();
        check_value("response count", 64'(rsp_count), 64'(need_count));
        end_test("6 random traffic");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/tile_cfg_pkg.sv
src/tile_mem_pkg.sv
src/ptw_req_decode.sv
src/dmem_arbiter.sv
src/dmem_resp_router.sv
src/dmem_port_top.sv
bench/dmem_port_chk.sv
bench/tb_dmem_port.sv

// ==== Bender.yml ====
package:
  name: dmem_port

sources:
  - src/tile_cfg_pkg.sv
  - src/tile_mem_pkg.sv
  - src/ptw_req_decode.sv
  - src/dmem_arbiter.sv
  - src/dmem_resp_router.sv
  - src/dmem_port_top.sv
  - target: test
    files:
      - bench/dmem_port_chk.sv
      - bench/tb_dmem_port.sv
